// ==== list.f ====
source/ula_video_pkg.sv
source/ula_bus_pkg.sv
source/raster_timer.sv
source/cpu_ports.sv
source/screen_pipe.sv
source/ula_top.sv
verification/ula_tb.sv

// ==== source/cpu_ports.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_ports import ula_bus_pkg::*; (
	input  wire        clk7,
	input  wire        rst_n,
	input  wire [15:0] addr,
	input  cpu_byte_t  cpu_data_in,
	input  wire        n_rd,
	input  wire        n_wr,
	input  wire        n_iorq,
	input  wire        n_m1,
	input  wire [4:0]  kd,
	input  wire        tape_in,
	input  cpu_byte_t  attr_next,
	output cpu_byte_t  cpu_data_out,
	output logic       cpu_data_oe,
	output logic [2:0] border,
	output logic       vbank,
	output logic       timing_128,
	output logic       beeper,
	output logic       tape_out
);

	logic        io_cycle, io_wr, io_rd;
	logic        fe_cs, p7ffd_cs, cfg_cs;
	logic        fe_mic, lock, fe_rd_q;
	port_write_u wr_byte;
	cpu_byte_t   fe_value;

	// m1 together with iorq is an interrupt acknowledge, not a port access
	assign io_cycle = !n_iorq && n_m1;
	assign io_wr    = io_cycle && !n_wr;
	assign io_rd    = io_cycle && !n_rd;

	assign fe_cs    = !addr[fe_addr_bit];
	assign p7ffd_cs = !addr[1] && !addr[15] && (addr[14] || addr[13]);
	assign cfg_cs   = addr[1:0] == cfg_addr_low;

	assign wr_byte = cpu_data_in;

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			border     <= '0;
			beeper     <= 1'b0;
			fe_mic     <= 1'b0;
			vbank      <= 1'b0;
			lock       <= 1'b0;
			timing_128 <= 1'b0;
		end else if (io_wr) begin
			if (fe_cs) begin
				border <= wr_byte.port_fe.border;
				beeper <= wr_byte.port_fe.beeper;
				fe_mic <= wr_byte.port_fe.mic;
			end
			// paging is frozen until reset once the lock bit is written
			if (p7ffd_cs && !lock) begin
				vbank <= wr_byte.paging.vbank;
				lock  <= wr_byte.paging.lock;
			end
			if (cfg_cs)
				timing_128 <= cpu_data_in[cfg_timing_bit];
		end
	end

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			cpu_data_oe <= 1'b0;
			fe_rd_q     <= 1'b0;
		end else begin
			cpu_data_oe <= io_rd;
			fe_rd_q     <= io_rd && fe_cs;
		end
	end

	// keyboard and tape are passed live while the read is held
	assign fe_value = {1'b1, tape_in, fe_read_fill, kd};

	// any other port returns the last attribute fetched as floating bus
	assign cpu_data_out = fe_rd_q ? fe_value : attr_next;

	assign tape_out = fe_mic ^ tape_in;

	oe_after_read: assert property (@(posedge clk7) disable iff (!rst_n)
		cpu_data_oe |-> $past(!n_iorq && !n_rd));

endmodule

`default_nettype wire

// ==== source/raster_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module raster_timer import ula_video_pkg::*; (
	input  wire     clk7,
	input  wire     rst_n,
	input  wire     timing_128,
	output hcount_t hc,
	output vcount_t vc,
	output logic    blank,
	output logic    hsync,
	output logic    vsync,
	output logic    csync,
	output logic    n_int,
	output logic    screen_load,
	output logic    screen_show,
	output logic    screen_update,
	output logic    line_end
);

	hcount_t h_last, hblank_from, hblank_to, hsync_from, hsync_to;
	hcount_t int_h_from, int_h_to;
	vcount_t v_last, vsync_from, vsync_to, int_v;
	logic    hsync0, vsync0, int_win;

	// geometry of the selected mode
	always_comb begin
		if (timing_128) begin
			h_last      = hcount_t'(h_total_128 - 1);
			hblank_from = hcount_t'(h_area + h_rborder_128);
			hsync_from  = hcount_t'(h_area + h_rborder_128 + h_blank1_128);
			hsync_to    = hcount_t'(h_area + h_rborder_128 + h_blank1_128 + h_sync_128);
			hblank_to   = hcount_t'(h_total_128 - h_lborder_128);
			v_last      = vcount_t'(v_total_128 - 1);
			vsync_from  = vcount_t'(v_area + v_bborder_128);
			vsync_to    = vcount_t'(v_area + v_bborder_128 + v_sync_128);
			int_v       = vcount_t'(int_v_128);
			int_h_from  = hcount_t'(int_h_from_128);
			int_h_to    = hcount_t'(int_h_to_128);
		end else begin
			h_last      = hcount_t'(h_total_pent - 1);
			hblank_from = hcount_t'(h_area + h_rborder_pent);
			hsync_from  = hcount_t'(h_area + h_rborder_pent + h_blank1_pent);
			hsync_to    = hcount_t'(h_area + h_rborder_pent + h_blank1_pent + h_sync_pent);
			hblank_to   = hcount_t'(h_total_pent - h_lborder_pent);
			v_last      = vcount_t'(v_total_pent - 1);
			vsync_from  = vcount_t'(v_area + v_bborder_pent);
			vsync_to    = vcount_t'(v_area + v_bborder_pent + v_sync_pent);
			int_v       = vcount_t'(int_v_pent);
			int_h_from  = hcount_t'(int_h_from_pent);
			int_h_to    = hcount_t'(int_h_to_pent);
		end
	end

	// >= so a mode switch mid line still wraps
	assign line_end = hc >= h_last;

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			hc <= '0;
			vc <= '0;
		end else if (line_end) begin
			hc <= '0;
			if (vc >= v_last)
				vc <= '0;
			else
				vc <= vc + 1'b1;
		end else begin
			hc <= hc + 1'b1;
		end
	end

	assign hsync0 = (hc >= hsync_from) && (hc < hsync_to);
	assign vsync0 = (vc >= vsync_from) && (vc < vsync_to);
	assign blank  = vsync0 || ((hc >= hblank_from) && (hc < hblank_to));
	assign int_win = (vc == int_v) && (hc >= int_h_from) && (hc < int_h_to);

	// fetch runs over the 256 screen columns
	// the shifter loads at column offset 6
	assign screen_load   = (vc < v_area) && (hc < h_area);
	assign screen_show   = (vc < v_area) && (hc >= screen_delay - 1)
		&& (hc < h_area + screen_delay - 1);
	assign screen_update = screen_load && (hc[2:0] == 3'(screen_delay - 2));

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b1;
			n_int <= 1'b1;
		end else begin
			hsync <= hsync0;
			vsync <= vsync0;
			csync <= ~(hsync0 ^ vsync0);
			n_int <= ~int_win;
		end
	end

	hc_in_line: assert property (@(posedge clk7) disable iff (!rst_n)
		$stable(timing_128) |-> hc <= h_last);

	int_on_int_line: assert property (@(posedge clk7) disable iff (!rst_n)
		!n_int && $stable(timing_128)
		|-> (vc == int_v) && (hc > int_h_from) && (hc <= int_h_to));

endmodule

`default_nettype wire

// ==== source/screen_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module screen_pipe import ula_video_pkg::*, ula_bus_pkg::*; (
	input  wire        clk7,
	input  wire        rst_n,
	input  hcount_t    hc,
	input  vcount_t    vc,
	input  wire        blank,
	input  wire        screen_load,
	input  wire        screen_show,
	input  wire        screen_update,
	input  wire        line_end,
	input  wire [2:0]  border,
	input  wire        vbank,
	input  wire        n_mreq,
	input  wire        n_rfsh,
	input  wire        n_iorq,
	input  cpu_byte_t  vram_data,
	output vram_addr_t vram_addr,
	output logic       vram_bank,
	output logic       vram_rd,
	output cpu_byte_t  attr_next,
	output logic       r,
	output logic       g,
	output logic       b,
	output logic       i
);

	logic                  bus_idle, fetch_en;
	logic                  fetch_attr, fetch_attr_q;
	vram_addr_t            bitmap_addr, attr_addr;
	cpu_byte_t             bitmap_next, bitmap, attr;
	logic [blink_bits-1:0] blink_cnt;
	logic                  line_end_q, blink, ink_sel;
	logic [2:0]            colour;

	// refresh cycles leave the video RAM free
	assign bus_idle = (n_mreq || !n_rfsh) && n_iorq;
	assign fetch_en = screen_load && bus_idle;

	// y7 y6 y2 y1 y0 y5 y4 y3 ordering of the Spectrum bitmap
	assign bitmap_addr = {bitmap_base, vc[7:6], vc[2:0], vc[5:3], hc[7:3]};
	assign attr_addr   = {attr_base, vc[7:3], hc[7:3]};
	assign vram_bank   = vbank;

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			vram_rd      <= 1'b0;
			vram_addr    <= '0;
			fetch_attr   <= 1'b0;
			fetch_attr_q <= 1'b0;
		end else begin
			vram_rd <= fetch_en;
			if (fetch_en) begin
				vram_addr    <= fetch_attr ? attr_addr : bitmap_addr;
				fetch_attr_q <= fetch_attr;
				fetch_attr   <= ~fetch_attr;
			end
		end
	end

	// data comes back in the cycle the address is on the bus
	always_ff @(posedge clk7) begin
		if (vram_rd && fetch_attr_q)
			attr_next <= vram_data;
		else if (!screen_load)
			attr_next <= 8'hff;
		if (vram_rd && !fetch_attr_q)
			bitmap_next <= vram_data;
	end

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			bitmap <= '0;
			attr   <= '0;
		end else if (screen_update) begin
			bitmap <= bitmap_next;
			attr   <= attr_next;
		end else begin
			bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	// one count per frame, seen the cycle after the last line wraps
	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			line_end_q <= 1'b0;
			blink_cnt  <= '0;
		end else begin
			line_end_q <= line_end;
			if (line_end_q && vc == '0)
				blink_cnt <= blink_cnt + 1'b1;
		end
	end

	assign blink   = blink_cnt[blink_bits-1];
	assign ink_sel = bitmap[7] ^ (attr[7] & blink);
	assign colour  = ink_sel ? attr[2:0] : attr[5:3];

	always_ff @(posedge clk7 or negedge rst_n) begin
		if (!rst_n) begin
			{g, r, b, i} <= 4'b0000;
		end else if (blank) begin
			{g, r, b, i} <= 4'b0000;
		end else if (!screen_show) begin
			{g, r, b} <= border;
			i <= 1'b0;
		end else begin
			{g, r, b} <= colour;
			// bright black stays black
			i <= attr[6] & (|colour);
		end
	end

endmodule

`default_nettype wire

// ==== source/ula_bus_pkg.sv ====
`default_nettype none

package ula_bus_pkg;

	typedef logic [7:0] cpu_byte_t;

	// port FE is selected by a low address bit 0
	localparam int fe_addr_bit = 0;
	// config port sits on address bits 1:0 both high
	localparam logic [1:0] cfg_addr_low = 2'b11;

	localparam int cfg_timing_bit = 0;
	// bit 5 of the FE read value is always high
	localparam logic fe_read_fill = 1'b1;

	typedef struct packed {
		logic [2:0] unused;
		logic       beeper;
		logic       mic;
		logic [2:0] border;
	} fe_view_t;

	typedef struct packed {
		logic [1:0] unused;
		logic       lock;
		logic       rom;
		logic       vbank;
		logic [2:0] ram;
	} paging_view_t;

	// one data bus byte, read as FE or as 7FFD depending on the port hit
	typedef union packed {
		fe_view_t     port_fe;
		paging_view_t paging;
	} port_write_u;

endpackage

`default_nettype wire

// ==== source/ula_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ula_top import ula_video_pkg::*, ula_bus_pkg::*; (
	input  wire        clk7,
	input  wire        rst_n,
	input  wire [15:0] addr,
	input  cpu_byte_t  cpu_data_in,
	input  wire        n_rd,
	input  wire        n_wr,
	input  wire        n_iorq,
	input  wire        n_m1,
	input  wire        n_mreq,
	input  wire        n_rfsh,
	input  wire [4:0]  kd,
	input  wire        tape_in,
	input  cpu_byte_t  vram_data,
	output cpu_byte_t  cpu_data_out,
	output wire        cpu_data_oe,
	output wire        beeper,
	output wire        tape_out,
	output vram_addr_t vram_addr,
	output wire        vram_bank,
	output wire        vram_rd,
	output wire        r,
	output wire        g,
	output wire        b,
	output wire        i,
	output wire        hsync,
	output wire        vsync,
	output wire        csync,
	output wire        n_int
);

	hcount_t   hc;
	vcount_t   vc;
	wire       blank, screen_load, screen_show, screen_update, line_end;
	wire [2:0] border;
	wire       vbank, timing_128;
	cpu_byte_t attr_next;

	raster_timer raster_timer_i (
		.clk7(clk7), .rst_n(rst_n), .timing_128(timing_128),
		.hc(hc), .vc(vc), .blank(blank),
		.hsync(hsync), .vsync(vsync), .csync(csync), .n_int(n_int),
		.screen_load(screen_load), .screen_show(screen_show),
		.screen_update(screen_update), .line_end(line_end)
	);

	cpu_ports cpu_ports_i (
		.clk7(clk7), .rst_n(rst_n), .addr(addr), .cpu_data_in(cpu_data_in),
		.n_rd(n_rd), .n_wr(n_wr), .n_iorq(n_iorq), .n_m1(n_m1),
		.kd(kd), .tape_in(tape_in), .attr_next(attr_next),
		.cpu_data_out(cpu_data_out), .cpu_data_oe(cpu_data_oe),
		.border(border), .vbank(vbank), .timing_128(timing_128),
		.beeper(beeper), .tape_out(tape_out)
	);

	screen_pipe screen_pipe_i (
		.clk7(clk7), .rst_n(rst_n), .hc(hc), .vc(vc), .blank(blank),
		.screen_load(screen_load), .screen_show(screen_show),
		.screen_update(screen_update), .line_end(line_end),
		.border(border), .vbank(vbank),
		.n_mreq(n_mreq), .n_rfsh(n_rfsh), .n_iorq(n_iorq),
		.vram_data(vram_data), .vram_addr(vram_addr), .vram_bank(vram_bank),
		.vram_rd(vram_rd), .attr_next(attr_next),
		.r(r), .g(g), .b(b), .i(i)
	);

endmodule

`default_nettype wire

// ==== source/ula_video_pkg.sv ====
`default_nettype none

package ula_video_pkg;

	// visible screen and pixel pipeline lead
	localparam int h_area       = 256;
	localparam int v_area       = 192;
	localparam int screen_delay = 8;

	// 128K raster, 456 clocks by 311 lines
	localparam int h_lborder_128 = 48 - screen_delay;
	localparam int h_rborder_128 = 48 + screen_delay;
	localparam int h_blank1_128  = 28;
	localparam int h_sync_128    = 33;
	localparam int h_blank2_128  = 43;
	localparam int h_total_128   = h_area + h_rborder_128 + h_blank1_128 + h_sync_128
		+ h_blank2_128 + h_lborder_128;
	localparam int v_bborder_128 = 56;
	localparam int v_sync_128    = 8;
	localparam int v_tborder_128 = 55;
	localparam int v_total_128   = v_area + v_bborder_128 + v_sync_128 + v_tborder_128;

	// Pentagon raster, 448 clocks by 320 lines
	localparam int h_lborder_pent = 72 - screen_delay;
	localparam int h_rborder_pent = 56 + screen_delay;
	localparam int h_blank1_pent  = 8;
	localparam int h_sync_pent    = 33;
	localparam int h_blank2_pent  = 23;
	localparam int h_total_pent   = h_area + h_rborder_pent + h_blank1_pent + h_sync_pent
		+ h_blank2_pent + h_lborder_pent;
	localparam int v_bborder_pent = 56;
	localparam int v_sync_pent    = 8;
	localparam int v_tborder_pent = 64;
	localparam int v_total_pent   = v_area + v_bborder_pent + v_sync_pent + v_tborder_pent;

	// frame interrupt position, h range is [from, to)
	localparam int int_v_128       = 248;
	localparam int int_h_from_128  = 5;
	localparam int int_h_to_128    = 64;
	localparam int int_v_pent      = 239;
	localparam int int_h_from_pent = 318;
	localparam int int_h_to_pent   = 384;

	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;
	typedef logic [14:0] vram_addr_t;

	// screen bitmap at 0x4000, attributes at 0x5800
	localparam logic [1:0] bitmap_base = 2'b10;
	localparam logic [4:0] attr_base   = 5'b10110;

	localparam int blink_bits = 5;

endpackage

`default_nettype wire

// ==== verification/ula_patterns.txt ====
// op addr data kd tape_in expected, all hex
// op 1 FE write, 2 7FFD write, 3 config write, 4 read, 5 frame, 6 pixel, 0 ends the list
4 00fe 00 1f 0 000000bf
4 7ffe 00 0a 1 000000ea
4 fefe 00 15 0 000000b5
4 00ff 00 00 0 000000ff
1 00fe 15 00 1 00000005
1 00fe 0a 00 1 00000002
1 00fe 1f 00 0 00000007
2 7ffd 08 00 0 00000001
2 7ffd 00 00 0 00000000
2 1ffd 08 00 0 00000000
2 5ffd 08 00 0 00000001
2 7ffd 28 00 0 00000001
2 7ffd 00 00 0 00000001
6 0000 45 00 0 0000000d
6 0000 05 00 0 00000005
6 0000 78 00 0 00000000
6 0000 47 00 0 0000000f
5 0000 42 00 0 00023000
3 00ff 01 00 0 00000000
5 0000 3b 00 0 000229f8
0 0000 00 00 0 00000000

// ==== verification/ula_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ula_tb
	import ula_video_pkg::*, ula_bus_pkg::*;
();

	localparam int pat_max   = 32;
	localparam int pat_words = 6;
	localparam int frame_max = h_total_pent * v_total_pent;
	// raster position of the first Pentagon cycle with n_int low
	localparam int int_fall_pos = int_v_pent * h_total_pent + int_h_from_pent + 1;

	logic        clk7, rst_n;
	logic [15:0] addr;
	cpu_byte_t   cpu_data_in, cpu_data_out, vram_data, attr_byte;
	logic        n_rd, n_wr, n_iorq, n_m1, n_mreq, n_rfsh;
	logic [4:0]  kd;
	logic        tape_in, cpu_data_oe, beeper, tape_out;
	vram_addr_t  vram_addr;
	logic        vram_bank, vram_rd, r, g, b, i;
	logic        hsync, vsync, csync, n_int;

	logic [31:0] pat_mem [0:pat_max*pat_words-1];
	int          pat_count;
	int          limit_cycles = 0;
	int unsigned seed_value;

	ula_top dut_i (
		.clk7(clk7), .rst_n(rst_n), .addr(addr), .cpu_data_in(cpu_data_in),
		.n_rd(n_rd), .n_wr(n_wr), .n_iorq(n_iorq), .n_m1(n_m1),
		.n_mreq(n_mreq), .n_rfsh(n_rfsh), .kd(kd), .tape_in(tape_in),
		.vram_data(vram_data), .cpu_data_out(cpu_data_out), .cpu_data_oe(cpu_data_oe),
		.beeper(beeper), .tape_out(tape_out), .vram_addr(vram_addr),
		.vram_bank(vram_bank), .vram_rd(vram_rd), .r(r), .g(g), .b(b), .i(i),
		.hsync(hsync), .vsync(vsync), .csync(csync), .n_int(n_int)
	);

	// bitmap reads as all ones and attributes come from the pattern
	assign vram_data = (vram_addr >= {attr_base, 10'h000}) ? attr_byte : 8'hff;

	initial begin
		clk7 = 1'b0;
		forever #50 clk7 = ~clk7;
	end

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_byte(input string name, input cpu_byte_t got, input cpu_byte_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// colour packed as {i, g, r, b} with bright on top
	task automatic check_rgbi(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input vram_addr_t got,
		input vram_addr_t exp_a, input vram_addr_t exp_b);
		if (got !== exp_a && got !== exp_b) begin
			$display("Fail %s: got %h, expected %h or %h", name, got, exp_a, exp_b);
			abort_run();
		end
	endtask

	// wait n clocks while keyboard and tape lines wander
	task automatic idle_cycles(input int n);
		logic [31:0] rnd;
		repeat (n) begin
			@(posedge clk7);
			#10;
			rnd = $urandom;
			kd = rnd[4:0];
			tape_in = rnd[5];
		end
	endtask

	task automatic wait_int_fall();
		logic last;
		do begin
			last = n_int;
			idle_cycles(1);
		end while (!(last && !n_int));
	endtask

	// only valid in Pentagon mode
	task automatic goto_raster(input int v, input int h);
		int steps;
		wait_int_fall();
		steps = (v * h_total_pent + h - int_fall_pos + frame_max) % frame_max;
		idle_cycles(steps);
	endtask

	task automatic io_start(input logic [15:0] a, input cpu_byte_t d, input logic wr,
		input logic [4:0] k, input logic t);
		addr = a;
		cpu_data_in = d;
		kd = k;
		tape_in = t;
		n_iorq = 1'b0;
		n_wr = !wr;
		n_rd = wr;
	endtask

	task automatic io_end();
		n_iorq = 1'b1;
		n_wr = 1'b1;
		n_rd = 1'b1;
		addr = 16'h0000;
	endtask

	task automatic run_pattern(input int k);
		logic [3:0]  op;
		logic [15:0] a;
		cpu_byte_t   d;
		logic [4:0]  kv;
		logic        t, last;
		logic [31:0] exp;
		int          cnt;
		op = pat_mem[k*pat_words][3:0];
		a = pat_mem[k*pat_words+1][15:0];
		d = pat_mem[k*pat_words+2][7:0];
		kv = pat_mem[k*pat_words+3][4:0];
		t = pat_mem[k*pat_words+4][0];
		exp = pat_mem[k*pat_words+5];
		case (op)
			4'd1: begin
				io_start(a, d, 1'b1, kv, t);
				@(posedge clk7);
				#10;
				check_bit("beeper", beeper, d[4]);
				check_bit("tape_out", tape_out, d[3] ^ t);
				io_end();
				// bottom border line left of horizontal blanking
				goto_raster(245, 100);
				check_rgbi("border rgbi", {i, g, r, b}, exp[3:0]);
				// same line inside horizontal sync
				idle_cycles(240);
				check_bit("hsync", hsync, 1'b1);
				check_bit("vsync", vsync, 1'b0);
				check_bit("csync", csync, 1'b0);
				// line 250 lies inside vertical sync
				idle_cycles(5 * h_total_pent - 240);
				check_bit("hsync", hsync, 1'b0);
				check_bit("vsync", vsync, 1'b1);
				check_bit("csync", csync, 1'b0);
			end
			4'd2, 4'd3: begin
				io_start(a, d, 1'b1, kv, t);
				idle_cycles(1);
				io_end();
				idle_cycles(1);
				if (op == 4'd2)
					check_bit("vram_bank", vram_bank, exp[0]);
			end
			4'd4: begin
				io_start(a, 8'h00, 1'b0, kv, t);
				check_bit("cpu_data_oe", cpu_data_oe, 1'b0);
				@(posedge clk7);
				#10;
				check_bit("cpu_data_oe", cpu_data_oe, 1'b1);
				check_byte("cpu_data_out", cpu_data_out, exp[7:0]);
				io_end();
				idle_cycles(1);
				check_bit("cpu_data_oe", cpu_data_oe, 1'b0);
			end
			4'd5: begin
				wait_int_fall();
				cnt = 0;
				do begin
					idle_cycles(1);
					cnt++;
				end while (!n_int);
				check_count("n_int low cycles", cnt, {24'h0, d});
				do begin
					last = n_int;
					idle_cycles(1);
					cnt++;
				end while (!(last && !n_int));
				check_count("frame cycles", cnt, exp);
			end
			4'd6: begin
				attr_byte = d;
				goto_raster(96, 128);
				check_rgbi("pixel rgbi", {i, g, r, b}, exp[3:0]);
				// last fetch is column 15 of line 96 at its bitmap or its attribute byte
				check_addr("vram_addr", vram_addr, 15'h488f, 15'h598f);
			end
			default: begin
				$display("pattern %0d has an unknown operation code %0d", k, op);
				abort_run();
			end
		endcase
	endtask

	initial begin
		int          waits;
		logic [31:0] op_word;
		seed_value = $urandom(32'hdeaf);
		rst_n = 1'b0;
		addr = 16'h0000;
		cpu_data_in = 8'h00;
		{n_rd, n_wr, n_iorq, n_m1, n_mreq, n_rfsh} = 6'b111111;
		kd = 5'h1f;
		tape_in = 1'b0;
		attr_byte = 8'hff;
		for (int k = 0; k < pat_max * pat_words; k++)
			pat_mem[k] = 32'h0;
		$readmemh("verification/ula_patterns.txt", pat_mem);
		pat_count = 0;
		waits = 0;
		while (pat_count < pat_max && pat_mem[pat_count*pat_words] != 32'h0) begin
			op_word = pat_mem[pat_count*pat_words];
			if (op_word == 32'd1 || op_word == 32'd5 || op_word == 32'd6)
				waits++;
			pat_count++;
		end
		if (pat_count == 0) begin
			$display("the pattern file holds no patterns");
			abort_run();
		end
		limit_cycles = (3 + 3 * waits) * frame_max + 2000 * pat_count;

		repeat (4) @(posedge clk7);
		#10;
		check_bit("n_int", n_int, 1'b1);
		check_bit("cpu_data_oe", cpu_data_oe, 1'b0);
		check_bit("vram_rd", vram_rd, 1'b0);
		check_rgbi("reset rgbi", {i, g, r, b}, 4'h0);
		rst_n = 1'b1;
		idle_cycles(16);

		for (int k = 0; k < pat_count; k++) begin
			run_pattern(k);
			idle_cycles(2);
		end
		$display("Test passed");
		$finish;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk7);
		$display("timeout: no result after %0d clock cycles", limit_cycles);
		abort_run();
	end

endmodule

`default_nettype wire
